// ==== sources.f ====
hdl/frame_fifo_pkg.sv
hdl/frame_fifo_wr.sv
hdl/frame_fifo_ram.sv
hdl/frame_fifo_rd.sv
hdl/frame_stats.sv
hdl/frame_fifo.sv
tb/frame_fifo_tb.sv

// ==== Makefile ====
TOP = frame_fifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== tb/frame_fifo_tb.sv ====
`timescale 1ns/1ps

module frame_fifo_tb;

  localparam int ADDR_WIDTH     = 4;
  localparam int DEPTH          = 2**ADDR_WIDTH;
  localparam int NUM_ROWS       = 12;
  localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 200;

  logic                  clk = 1'b0;
  logic                  rst = 1'b1;
  frame_fifo_pkg::data_t in_data;
  logic                  in_last;
  logic                  in_user;
  logic                  in_valid;
  logic                  in_ready;
  frame_fifo_pkg::data_t m_data;
  logic                  m_last;
  logic                  m_valid;
  logic                  m_ready = 1'b0;
  frame_fifo_pkg::cnt_t  good_count;
  frame_fifo_pkg::cnt_t  bad_count;
  frame_fifo_pkg::cnt_t  overflow_count;

  // stimulus table with one frame per row
  string                 row_name  [NUM_ROWS];
  int                    row_len   [NUM_ROWS];
  bit                    row_bad   [NUM_ROWS];
  frame_fifo_pkg::data_t row_seed  [NUM_ROWS];
  int                    row_beats [NUM_ROWS]; // output beats expected
  int                    row_count = 0;

  logic [8:0] ref_q [$]; // {last, data}
  int         exp_good = 0;
  int         exp_bad = 0;
  int         exp_ovf = 0;
  string      cur_name = "reset";
  int         out_beats = 0;
  int         cycle_count = 0;
  integer     seed = 32'h648f;

  frame_fifo #(.ADDR_WIDTH(ADDR_WIDTH)) DUT (
    .clk            (clk),
    .rst            (rst),
    .in_data        (in_data),
    .in_last        (in_last),
    .in_user        (in_user),
    .in_valid       (in_valid),
    .in_ready       (in_ready),
    .m_data         (m_data),
    .m_last         (m_last),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input string what, input int exp, input int act);
    $display("ERR %s %s expected %0h actual %0h", name, what, exp, act);
    stop_with_failure();
  endtask

  task automatic fail_text(input string msg);
    $display("%s", msg);
    stop_with_failure();
  endtask

  task automatic add_row(input string name, input int len, input bit bad,
                         input frame_fifo_pkg::data_t seed_off, input int beats);
    row_name[row_count]  = name;
    row_len[row_count]   = len;
    row_bad[row_count]   = bad;
    row_seed[row_count]  = seed_off;
    row_beats[row_count] = beats;
    row_count++;
  endtask

  task automatic load_table();
    add_row("single_beat",    1,  1'b0, 8'h10, 1);
    add_row("five_beats",     5,  1'b0, 8'h20, 5);
    add_row("full_depth",     16, 1'b0, 8'h30, 16);
    add_row("bad_five",       5,  1'b1, 8'h40, 0);
    add_row("good_after_bad", 4,  1'b0, 8'h50, 4);
    add_row("overflow_20",    20, 1'b0, 8'h60, 0);
    add_row("good_after_ovf", 16, 1'b0, 8'h80, 16);
    add_row("bad_single",     1,  1'b1, 8'h90, 0);
    add_row("seven_beats",    7,  1'b0, 8'ha0, 7);
    add_row("overflow_17",    17, 1'b0, 8'hb0, 0);
    add_row("byte_wrap",      2,  1'b0, 8'hff, 2);
    add_row("full_again",     16, 1'b0, 8'hc0, 16);
  endtask

  // expected outcome of one row
  task automatic expect_row(input int r);
    logic       is_last;
    logic [8:0] beat;
    if (row_len[r] > DEPTH) begin
      exp_ovf++;
    end else if (row_bad[r]) begin
      exp_bad++;
    end else begin
      exp_good++;
      for (int k = 0; k < row_len[r]; k++) begin
        is_last = (k == row_len[r] - 1);
        beat = {is_last, frame_fifo_pkg::data_t'(row_seed[r] + k)};
        ref_q.push_back(beat);
      end
    end
  endtask

  task automatic send_row(input int r);
    for (int k = 0; k < row_len[r]; k++) begin
      @(negedge clk);
      in_valid = 1'b1;
      in_data  = frame_fifo_pkg::data_t'(row_seed[r] + k);
      in_last  = (k == row_len[r] - 1);
      in_user  = row_bad[r] && (k == row_len[r] - 1); // flag rides on the last beat
      assert (in_ready == 1'b1)
        else fail_value(cur_name, "in_ready", 1, int'(in_ready));
    end
    @(negedge clk);
    in_valid = 1'b0;
    in_last  = 1'b0;
    in_user  = 1'b0;
  endtask

  // memory is empty once the queue is empty and the output stays idle
  task automatic drain();
    int idle;
    idle = 0;
    while (ref_q.size() != 0 || idle < 4) begin
      @(negedge clk);
      if (m_valid) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
  endtask

  task automatic check_counts(input string name);
    assert (int'(good_count) == exp_good)
      else fail_value(name, "good_count", exp_good, int'(good_count));
    assert (int'(bad_count) == exp_bad)
      else fail_value(name, "bad_count", exp_bad, int'(bad_count));
    assert (int'(overflow_count) == exp_ovf)
      else fail_value(name, "overflow_count", exp_ovf, int'(overflow_count));
  endtask

  // random-ready sink that checks each beat taken on the next rising edge
  always @(negedge clk) begin : sink
    logic [8:0] exp_beat;
    m_ready = ($random(seed) & 3) != 0;
    if (m_valid && m_ready) begin
      assert (ref_q.size() > 0) else fail_text("output beat arrived with no frame pending");
      exp_beat = ref_q.pop_front();
      out_beats++;
      assert (m_data == exp_beat[7:0])
        else fail_value(cur_name, "m_data", int'(exp_beat[7:0]), int'(m_data));
      assert (m_last == exp_beat[8])
        else fail_value(cur_name, "m_last", int'(exp_beat[8]), int'(m_last));
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      fail_text("timeout waiting for output");
    end
  end

  initial begin
    in_data  = '0;
    in_last  = 1'b0;
    in_user  = 1'b0;
    in_valid = 1'b0;
    load_table();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    cur_name = "after_reset";
    assert (m_valid == 1'b0) else fail_value(cur_name, "m_valid", 0, int'(m_valid));
    assert (in_ready == 1'b1) else fail_value(cur_name, "in_ready", 1, int'(in_ready));
    check_counts(cur_name);

    for (int r = 0; r < row_count; r++) begin
      cur_name  = row_name[r];
      out_beats = 0;
      expect_row(r);
      send_row(r);
      drain();
      assert (out_beats == row_beats[r])
        else fail_value(cur_name, "beat count", row_beats[r], out_beats);
      check_counts(cur_name);
    end

    $display("All checks passed");
    $finish;
  end

endmodule

// ==== hdl/frame_fifo.sv ====
`timescale 1ns/1ps

module frame_fifo #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  frame_fifo_pkg::data_t in_data,
  input  logic                  in_last,
  input  logic                  in_user,
  input  logic                  in_valid,
  output logic                  in_ready,
  output frame_fifo_pkg::data_t m_data,
  output logic                  m_last,
  output logic                  m_valid,
  input  logic                  m_ready,
  output frame_fifo_pkg::cnt_t  good_count,
  output frame_fifo_pkg::cnt_t  bad_count,
  output frame_fifo_pkg::cnt_t  overflow_count
);

  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  frame_fifo_pkg::word_t wr_word;
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_addr;
  frame_fifo_pkg::word_t rd_word;
  logic [ADDR_WIDTH:0]   commit_ptr;
  logic [ADDR_WIDTH:0]   rd_ptr;
  logic                  good_frame;
  logic                  bad_frame;
  logic                  overflow;

  frame_fifo_wr #(.ADDR_WIDTH(ADDR_WIDTH)) u_wr (
    .clk        (clk),
    .rst        (rst),
    .in_data    (in_data),
    .in_last    (in_last),
    .in_user    (in_user),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .rd_ptr     (rd_ptr),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_word    (wr_word),
    .commit_ptr (commit_ptr),
    .good_frame (good_frame),
    .bad_frame  (bad_frame),
    .overflow   (overflow)
  );

  frame_fifo_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_word (wr_word),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_word (rd_word)
  );

  frame_fifo_rd #(.ADDR_WIDTH(ADDR_WIDTH)) u_rd (
    .clk        (clk),
    .rst        (rst),
    .commit_ptr (commit_ptr),
    .rd_ptr     (rd_ptr),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_word    (rd_word),
    .m_data     (m_data),
    .m_last     (m_last),
    .m_valid    (m_valid),
    .m_ready    (m_ready)
  );

  frame_stats u_stats (
    .clk            (clk),
    .rst            (rst),
    .good_frame     (good_frame),
    .bad_frame      (bad_frame),
    .overflow       (overflow),
    .good_count     (good_count),
    .bad_count      (bad_count),
    .overflow_count (overflow_count)
  );

endmodule

// ==== hdl/frame_stats.sv ====
`timescale 1ns/1ps

module frame_stats (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 good_frame,
  input  logic                 bad_frame,
  input  logic                 overflow,
  output frame_fifo_pkg::cnt_t good_count,
  output frame_fifo_pkg::cnt_t bad_count,
  output frame_fifo_pkg::cnt_t overflow_count
);

  localparam frame_fifo_pkg::cnt_t CNT_MAX = {frame_fifo_pkg::CNT_WIDTH{1'b1}};
  localparam frame_fifo_pkg::cnt_t CNT_ONE = 1;

  // stick at max instead of wrapping
  function automatic frame_fifo_pkg::cnt_t sat_inc(input frame_fifo_pkg::cnt_t c);
    return (c == CNT_MAX) ? c : c + CNT_ONE;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      good_count     <= '0;
      bad_count      <= '0;
      overflow_count <= '0;
    end else begin
      if (good_frame) begin
        good_count <= sat_inc(good_count);
      end
      if (bad_frame) begin
        bad_count <= sat_inc(bad_count);
      end
      if (overflow) begin
        overflow_count <= sat_inc(overflow_count);
      end
    end
  end

endmodule

// ==== hdl/frame_fifo_rd.sv ====
`timescale 1ns/1ps

module frame_fifo_rd #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ADDR_WIDTH:0]   commit_ptr,
  output logic [ADDR_WIDTH:0]   rd_ptr,
  output logic                  rd_en,
  output logic [ADDR_WIDTH-1:0] rd_addr,
  input  frame_fifo_pkg::word_t rd_word,
  output frame_fifo_pkg::data_t m_data,
  output logic                  m_last,
  output logic                  m_valid,
  input  logic                  m_ready
);

  localparam logic [ADDR_WIDTH:0] PTR_ONE = 1;

  logic empty;
  logic pf_valid; // ram output register holds a word
  logic pf_free;
  logic store;

  assign empty   = rd_ptr == commit_ptr;
  assign store   = m_ready | ~m_valid;
  assign pf_free = store | ~pf_valid;
  assign rd_en   = pf_free & ~empty;
  assign rd_addr = rd_ptr[ADDR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr   <= '0;
      pf_valid <= 1'b0;
      m_valid  <= 1'b0;
    end else begin
      if (rd_en) begin
        rd_ptr <= rd_ptr + PTR_ONE;
      end
      if (pf_free) begin
        pf_valid <= ~empty;
      end
      if (store) begin
        m_valid <= pf_valid;
      end
    end
  end

  // output register
  always_ff @(posedge clk) begin
    if (store) begin
      m_data <= rd_word[frame_fifo_pkg::DATA_WIDTH-1:0];
      m_last <= rd_word[frame_fifo_pkg::LAST_BIT];
    end
  end

endmodule

// ==== hdl/frame_fifo_ram.sv ====
`timescale 1ns/1ps

module frame_fifo_ram #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                  clk,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  frame_fifo_pkg::word_t wr_word,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  output frame_fifo_pkg::word_t rd_word
);

  frame_fifo_pkg::word_t mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
    // registered read that holds when idle
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

endmodule

// ==== hdl/frame_fifo_wr.sv ====
`timescale 1ns/1ps

module frame_fifo_wr #(
  parameter int ADDR_WIDTH = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  frame_fifo_pkg::data_t   in_data,
  input  logic                    in_last,
  input  logic                    in_user,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  logic [ADDR_WIDTH:0]     rd_ptr,
  output logic                    wr_en,
  output logic [ADDR_WIDTH-1:0]   wr_addr,
  output frame_fifo_pkg::word_t   wr_word,
  output logic [ADDR_WIDTH:0]     commit_ptr,
  output logic                    good_frame,
  output logic                    bad_frame,
  output logic                    overflow
);

  typedef enum logic {
    WR_PASS,
    WR_DROP
  } wr_state_t;

  // pointers one depth apart differ only in the wrap bit
  localparam logic [ADDR_WIDTH:0] WRAP    = {1'b1, {ADDR_WIDTH{1'b0}}};
  localparam logic [ADDR_WIDTH:0] PTR_ONE = 1;

  wr_state_t           state;
  wr_state_t           state_next;
  logic [ADDR_WIDTH:0] cur_ptr;
  logic [ADDR_WIDTH:0] cur_next;
  logic [ADDR_WIDTH:0] commit_next;
  logic                accept;
  logic                full_cur;
  logic                full_wr;
  logic                good_next;
  logic                bad_next;
  logic                ovf_next;

  assign accept   = in_valid & in_ready;
  assign full_cur = (cur_ptr ^ rd_ptr) == WRAP;     // memory full
  assign full_wr  = (cur_ptr ^ commit_ptr) == WRAP; // frame larger than memory
  assign wr_addr  = cur_ptr[ADDR_WIDTH-1:0];

  always_comb begin
    wr_word = '0;
    wr_word[frame_fifo_pkg::DATA_WIDTH-1:0] = in_data;
    wr_word[frame_fifo_pkg::LAST_BIT] = in_last;
    wr_word[frame_fifo_pkg::USER_BIT] = in_user;
  end

  always_comb begin
    state_next  = state;
    cur_next    = cur_ptr;
    commit_next = commit_ptr;
    wr_en       = 1'b0;
    good_next   = 1'b0;
    bad_next    = 1'b0;
    ovf_next    = 1'b0;
    if (accept) begin
      if (state == WR_DROP || full_cur || full_wr) begin
        // swallow the rest of the frame
        state_next = WR_DROP;
        if (in_last) begin
          state_next = WR_PASS;
          cur_next   = commit_ptr;
          ovf_next   = 1'b1;
        end
      end else begin
        wr_en    = 1'b1;
        cur_next = cur_ptr + PTR_ONE;
        if (in_last) begin
          if (in_user) begin
            cur_next = commit_ptr; // rewind to drop the bad frame
            bad_next = 1'b1;
          end else begin
            commit_next = cur_ptr + PTR_ONE;
            good_next   = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= WR_PASS;
      cur_ptr    <= '0;
      commit_ptr <= '0;
      in_ready   <= 1'b0;
      good_frame <= 1'b0;
      bad_frame  <= 1'b0;
      overflow   <= 1'b0;
    end else begin
      state      <= state_next;
      cur_ptr    <= cur_next;
      commit_ptr <= commit_next;
      in_ready   <= 1'b1; // never back-pressures
      good_frame <= good_next;
      bad_frame  <= bad_next;
      overflow   <= ovf_next;
    end
  end

endmodule

// ==== hdl/frame_fifo_pkg.sv ====
package frame_fifo_pkg;

  // one payload beat
  localparam int DATA_WIDTH = 8;

  // stored word from the lsb up holds payload then last then user
  localparam int LAST_BIT   = DATA_WIDTH;
  localparam int USER_BIT   = DATA_WIDTH + 1;
  localparam int WORD_WIDTH = DATA_WIDTH + 2;

  // frame counters
  localparam int CNT_WIDTH = 16;

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [WORD_WIDTH-1:0] word_t;
  typedef logic [CNT_WIDTH-1:0]  cnt_t;

endpackage
